//--- sources.f
source/hart_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/mem_align.sv
source/hart.sv
tests/clock_gen.sv
tests/hart_properties.sv
tests/hart_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= hart_tb
SEED      ?= 42412
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only when the pass line shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)

//--- tests/hart_tb.sv
module hart_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    hart_pkg::word_t     pc;
    hart_pkg::reg_addr_t rd;
    hart_pkg::word_t     data; // only compared when rd is not x0
  } retire_exp_t;

  logic                clk;
  logic                rst;
  hart_pkg::word_t     imem_raddr;
  hart_pkg::word_t     imem_rdata;
  hart_pkg::dmem_req_t dmem;
  hart_pkg::word_t     dmem_rdata;
  hart_pkg::retire_t   retire;
  hart_pkg::word_t     imem [0:255]; // program with one word per instruction
  hart_pkg::word_t     dmem_words [0:255];
  retire_exp_t         expected [$]; // retire order the program must produce
  string               names [$];
  hart_pkg::word_t     pc; // where the next program word is placed
  int                  seed;
  int                  cycles;

  clock_gen clock_gen_inst (.o_clk(clk));

  hart hart_inst (
    .i_clk(clk), .i_rst(rst), .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
    .o_dmem(dmem), .i_dmem_rdata(dmem_rdata), .o_retire(retire)
  );

  bind hart hart_properties hart_properties_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_dmem(o_dmem), .i_retire(o_retire)
  );

  assign imem_rdata = imem[imem_raddr[9:2]]; // both memories answer in the same cycle
  assign dmem_rdata = dmem.ren ? dmem_words[dmem.addr[9:2]] : '0; // zero unless read

  // only the masked lanes change at the rising edge
  always @(posedge clk) begin
    if (dmem.wen) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (dmem.mask[lane]) begin
          dmem_words[dmem.addr[9:2]][8*lane +: 8] <= dmem.wdata[8*lane +: 8];
        end
      end
    end
  end

  // RV32I encoders
  function automatic hart_pkg::word_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, hart_pkg::opc_op};
  endfunction

  function automatic hart_pkg::word_t i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic hart_pkg::word_t s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], hart_pkg::opc_store};
  endfunction

  function automatic hart_pkg::word_t b_type(input logic [12:0] off, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], hart_pkg::opc_branch};
  endfunction

  function automatic hart_pkg::word_t u_type(input logic [19:0] imm, input logic [4:0] rd,
                                             input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic hart_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, hart_pkg::opc_jal};
  endfunction

  function automatic hart_pkg::word_t nop_word();
    return i_type(12'd0, 5'd0, 3'b000, 5'd0, hart_pkg::opc_op_imm); // addi x0, x0, 0
  endfunction

  task automatic place(input hart_pkg::word_t inst);
    imem[pc[9:2]] = inst;
    pc = pc + 32'd4;
  endtask

  // a word in the shadow of a taken transfer must never retire
  task automatic place_shadow();
    place(nop_word());
  endtask

  task automatic emit(input string name, input hart_pkg::word_t inst,
                      input hart_pkg::reg_addr_t rd, input hart_pkg::word_t data);
    retire_exp_t entry;
    entry.pc   = pc;
    entry.rd   = rd;
    entry.data = data;
    expected.push_back(entry);
    names.push_back(name);
    place(inst);
  endtask

  task automatic load_const(input string name, input hart_pkg::reg_addr_t rd,
                            input hart_pkg::word_t value);
    hart_pkg::word_t upper;
    upper = value + 32'h800; // addi adds the low part sign extended
    upper[11:0] = 12'h000;
    emit({name, " lui"}, u_type(upper[31:12], rd, hart_pkg::opc_lui), rd, upper);
    emit({name, " addi"}, i_type(value[11:0], rd, 3'b000, rd, hart_pkg::opc_op_imm), rd, value);
  endtask

  // the branch goes to pc + 12 and the two words in between retire only on fall through
  task automatic branch_test(input string name, input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic taken);
    emit(name, b_type(13'd12, rs2, rs1, f3), 5'd0, '0);
    if (taken) begin
      place_shadow();
      place_shadow();
    end else begin
      emit({name, " fall through"}, nop_word(), 5'd0, '0);
      emit({name, " fall through"}, nop_word(), 5'd0, '0);
    end
  endtask

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic build_program();
    hart_pkg::word_t ra;
    hart_pkg::word_t rb;
    hart_pkg::word_t immx;
    hart_pkg::word_t tgt;
    hart_pkg::word_t link;
    ra   = $random(seed);
    rb   = $random(seed);
    immx = 32'hffff_fff9; // -7 sign extended
    load_const("load a", 5'd1, ra);
    load_const("load b", 5'd2, rb);
    emit("add", r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, ra + rb);
    emit("sub", r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, ra - rb);
    emit("sll", r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd5), 5'd5, ra << rb[4:0]);
    emit("slt", r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd6), 5'd6,
         ($signed(ra) < $signed(rb)) ? 32'd1 : 32'd0);
    emit("sltu", r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd7), 5'd7, (ra < rb) ? 32'd1 : 32'd0);
    emit("xor", r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 5'd8, ra ^ rb);
    emit("srl", r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd9), 5'd9, ra >> rb[4:0]);
    emit("sra", r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd10), 5'd10, $signed(ra) >>> rb[4:0]);
    emit("or", r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 5'd11, ra | rb);
    emit("and", r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 5'd12, ra & rb);
    emit("addi", i_type(12'hff9, 5'd1, 3'b000, 5'd13, hart_pkg::opc_op_imm), 5'd13, ra + immx);
    emit("slti", i_type(12'hff9, 5'd1, 3'b010, 5'd14, hart_pkg::opc_op_imm), 5'd14,
         ($signed(ra) < $signed(immx)) ? 32'd1 : 32'd0);
    emit("sltiu", i_type(12'hff9, 5'd1, 3'b011, 5'd15, hart_pkg::opc_op_imm), 5'd15,
         (ra < immx) ? 32'd1 : 32'd0);
    emit("xori", i_type(12'hff9, 5'd1, 3'b100, 5'd16, hart_pkg::opc_op_imm), 5'd16, ra ^ immx);
    emit("ori", i_type(12'hff9, 5'd1, 3'b110, 5'd17, hart_pkg::opc_op_imm), 5'd17, ra | immx);
    emit("andi", i_type(12'hff9, 5'd1, 3'b111, 5'd18, hart_pkg::opc_op_imm), 5'd18, ra & immx);
    emit("slli", i_type(12'h00d, 5'd1, 3'b001, 5'd19, hart_pkg::opc_op_imm), 5'd19, ra << 13);
    emit("srli", i_type(12'h00d, 5'd1, 3'b101, 5'd20, hart_pkg::opc_op_imm), 5'd20, ra >> 13);
    emit("srai", i_type(12'h40d, 5'd1, 3'b101, 5'd21, hart_pkg::opc_op_imm), 5'd21,
         $signed(ra) >>> 13);
    emit("lui", u_type(20'habcde, 5'd22, hart_pkg::opc_lui), 5'd22, 32'habcd_e000);
    emit("auipc", u_type(20'h12345, 5'd23, hart_pkg::opc_auipc), 5'd23, pc + 32'h1234_5000);
    // each result feeds the very next instruction
    emit("chain 1", i_type(12'd1, 5'd1, 3'b000, 5'd24, hart_pkg::opc_op_imm), 5'd24, ra + 1);
    emit("chain 2", r_type(7'h00, 5'd24, 5'd24, 3'b000, 5'd25), 5'd25, (ra + 1) << 1);
    emit("chain 3", r_type(7'h20, 5'd1, 5'd25, 3'b000, 5'd26), 5'd26, ra + 2);
    emit("write x0", i_type(12'd5, 5'd26, 3'b000, 5'd0, hart_pkg::opc_op_imm), 5'd0, '0);
    emit("x0 stays zero", r_type(7'h00, 5'd26, 5'd0, 3'b000, 5'd27), 5'd27, ra + 2);
    emit("x0 read twice", r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd28), 5'd28, 32'd0);
    emit("base addr", i_type(12'h100, 5'd0, 3'b000, 5'd20, hart_pkg::opc_op_imm), 5'd20, 32'h100);
    emit("sw word 0", s_type(12'd0, 5'd1, 5'd20, 3'b010), 5'd0, '0);
    emit("sb lane 0", s_type(12'd0, 5'd2, 5'd20, 3'b000), 5'd0, '0);
    emit("sb lane 3", s_type(12'd3, 5'd2, 5'd20, 3'b000), 5'd0, '0);
    emit("lw lanes 0 3", i_type(12'd0, 5'd20, 3'b010, 5'd21, hart_pkg::opc_load), 5'd21,
         {rb[7:0], ra[23:8], rb[7:0]});
    emit("sw word 1", s_type(12'd4, 5'd1, 5'd20, 3'b010), 5'd0, '0);
    emit("sb lane 1", s_type(12'd5, 5'd2, 5'd20, 3'b000), 5'd0, '0);
    emit("sb lane 2", s_type(12'd6, 5'd2, 5'd20, 3'b000), 5'd0, '0);
    emit("lw lanes 1 2", i_type(12'd4, 5'd20, 3'b010, 5'd21, hart_pkg::opc_load), 5'd21,
         {ra[31:24], rb[7:0], rb[7:0], ra[7:0]});
    emit("sw word 2", s_type(12'd8, 5'd1, 5'd20, 3'b010), 5'd0, '0);
    emit("sh upper", s_type(12'd10, 5'd2, 5'd20, 3'b001), 5'd0, '0);
    emit("lw sh upper", i_type(12'd8, 5'd20, 3'b010, 5'd22, hart_pkg::opc_load), 5'd22,
         {rb[15:0], ra[15:0]});
    emit("sh lower", s_type(12'd8, 5'd2, 5'd20, 3'b001), 5'd0, '0);
    emit("lw sh lower", i_type(12'd8, 5'd20, 3'b010, 5'd23, hart_pkg::opc_load), 5'd23,
         {rb[15:0], rb[15:0]});
    // 7f80a55a has a negative and a positive byte and half word
    load_const("load c", 5'd24, 32'h7f80_a55a);
    emit("sw c", s_type(12'd12, 5'd24, 5'd20, 3'b010), 5'd0, '0);
    emit("lb 1", i_type(12'd13, 5'd20, 3'b000, 5'd25, hart_pkg::opc_load), 5'd25, 32'hffff_ffa5);
    emit("lb 2", i_type(12'd14, 5'd20, 3'b000, 5'd26, hart_pkg::opc_load), 5'd26, 32'hffff_ff80);
    emit("lb 3", i_type(12'd15, 5'd20, 3'b000, 5'd27, hart_pkg::opc_load), 5'd27, 32'h0000_007f);
    emit("lbu 1", i_type(12'd13, 5'd20, 3'b100, 5'd28, hart_pkg::opc_load), 5'd28, 32'h0000_00a5);
    emit("lh 0", i_type(12'd12, 5'd20, 3'b001, 5'd29, hart_pkg::opc_load), 5'd29, 32'hffff_a55a);
    emit("lh 2", i_type(12'd14, 5'd20, 3'b001, 5'd30, hart_pkg::opc_load), 5'd30, 32'h0000_7f80);
    emit("lhu 0", i_type(12'd12, 5'd20, 3'b101, 5'd31, hart_pkg::opc_load), 5'd31, 32'h0000_a55a);
    emit("lw c", i_type(12'd12, 5'd20, 3'b010, 5'd31, hart_pkg::opc_load), 5'd31, 32'h7f80_a55a);
    branch_test("beq same", 3'b000, 5'd1, 5'd1, 1'b1);
    branch_test("bne same", 3'b001, 5'd1, 5'd1, 1'b0);
    branch_test("beq a b", 3'b000, 5'd1, 5'd2, ra == rb);
    branch_test("bne a b", 3'b001, 5'd1, 5'd2, ra != rb);
    branch_test("blt a b", 3'b100, 5'd1, 5'd2, $signed(ra) < $signed(rb));
    branch_test("bge a b", 3'b101, 5'd1, 5'd2, $signed(ra) >= $signed(rb));
    branch_test("bltu a b", 3'b110, 5'd1, 5'd2, ra < rb);
    branch_test("bgeu a b", 3'b111, 5'd1, 5'd2, ra >= rb);
    emit("jal", j_type(21'd12, 5'd5), 5'd5, pc + 32'd4);
    place_shadow();
    place_shadow();
    tgt = pc + 32'd16; // addi, jalr and two shadow words come first
    emit("jalr base", i_type(tgt[11:0], 5'd0, 3'b000, 5'd7, hart_pkg::opc_op_imm), 5'd7, tgt);
    link = pc + 32'd4;
    emit("jalr", i_type(12'd1, 5'd7, 3'b000, 5'd6, hart_pkg::opc_jalr), 5'd6, link); // bit 0 drops
    place_shadow();
    place_shadow();
    emit("link read back", r_type(7'h00, 5'd0, 5'd6, 3'b000, 5'd8), 5'd8, link);
  endtask

  task automatic check_retire(input int idx);
    retire_exp_t want;
    want = expected[idx];
    assert (retire.pc == want.pc) else begin
      $display("FAILED %s: pc expected %h actual %h", names[idx], want.pc, retire.pc);
      abort_run();
    end
    assert (retire.rd == want.rd) else begin
      $display("FAILED %s: rd expected %0d actual %0d", names[idx], want.rd, retire.rd);
      abort_run();
    end
    assert (want.rd == 5'd0 || retire.data == want.data) else begin
      $display("FAILED %s: data expected %h actual %h", names[idx], want.data, retire.data);
      abort_run();
    end
  endtask

  initial begin
    rst  = 1'b1;
    seed = 42412;
    pc   = hart_pkg::reset_addr;
    for (int i = 0; i < 256; i++) begin
      imem[i]       = '0; // all zero decodes as illegal and never retires
      dmem_words[i] = (i * 32'h9e37_79b9) ^ 32'h5a3c_c3a5;
    end
    build_program();
    repeat (4) begin
      @(negedge clk);
      assert (!retire.valid) else begin
        $display("an instruction retired while reset was high");
        abort_run();
      end
      assert (!dmem.ren && !dmem.wen) else begin
        $display("the data memory port was enabled while reset was high");
        abort_run();
      end
    end
    rst = 1'b0;
    foreach (expected[i]) begin
      cycles = 0;
      do begin
        @(negedge clk); // outputs are settled half a cycle after the rising edge
        cycles++;
      end while (!retire.valid && cycles < 20);
      assert (retire.valid) else begin
        $display("no instruction retired within 20 cycles while waiting for %s", names[i]);
        abort_run();
      end
      check_retire(i);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

//--- tests/hart_properties.sv
module hart_properties (
  input logic                i_clk,
  input logic                i_rst,
  input hart_pkg::dmem_req_t i_dmem,
  input hart_pkg::retire_t   i_retire
);
  timeunit 1ns;
  timeprecision 1ps;

  // the data port carries one access per cycle
  one_access: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem.ren && i_dmem.wen))
    else $error("dmem read and write enabled in the same cycle");

  lanes_on: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_dmem.ren || i_dmem.wen) |-> i_dmem.mask != 4'b0000) // an access touches some lane
    else $error("dmem access with an empty byte mask");

  pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire.valid |-> i_retire.pc[1:0] == 2'b00)
    else $error("retired pc is not word aligned");

  // sampled on the falling edge so the reset edge itself has settled the pipeline
  quiet_in_reset: assert property (@(negedge i_clk) i_rst |-> !i_retire.valid)
    else $error("instruction retired while reset was high");

endmodule

//--- tests/clock_gen.sv
module clock_gen (
  output logic o_clk
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0; // first rising edge at 5 ns
    forever #5 o_clk = ~o_clk; // 10 ns period
  end

endmodule

//--- source/hart.sv
module hart (
  input  logic                i_clk,
  input  logic                i_rst,
  output hart_pkg::word_t     o_imem_raddr,
  input  hart_pkg::word_t     i_imem_rdata,
  output hart_pkg::dmem_req_t o_dmem,
  input  hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::retire_t   o_retire
);

  hart_pkg::fetch_pkt_t fetch_pkt;
  hart_pkg::exec_pkt_t  exec_pkt;
  hart_pkg::wb_pkt_t    wb;
  hart_pkg::dmem_req_t  dmem_req; // byte addressed request from execute
  hart_pkg::reg_addr_t  rs1_addr;
  hart_pkg::reg_addr_t  rs2_addr;
  hart_pkg::word_t      rs1_data;
  hart_pkg::word_t      rs2_data;
  hart_pkg::word_t      load_data;
  hart_pkg::word_t      target;
  logic                 redirect; // also flushes decode

  fetch_stage fetch_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_redirect(redirect), .i_target(target),
    .i_imem_rdata(i_imem_rdata), .o_imem_raddr(o_imem_raddr), .o_fetch(fetch_pkt)
  );

  decode_stage decode_inst (
    .i_clk(i_clk), .i_rst(i_rst), .i_fetch(fetch_pkt), .i_flush(redirect),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_exec(exec_pkt)
  );

  reg_file reg_file_inst (
    .i_clk(i_clk), .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data), .i_wb(wb)
  );

  execute_stage execute_inst (
    .i_exec(exec_pkt), .i_load_data(load_data), .o_dmem_req(dmem_req), .o_wb(wb),
    .o_redirect(redirect), .o_target(target), .o_retire(o_retire)
  );

  // access size comes straight from the instruction in execute
  mem_align mem_align_inst (
    .i_req(dmem_req), .i_funct3(exec_pkt.funct3), .i_rdata(i_dmem_rdata),
    .o_dmem(o_dmem), .o_load_data(load_data)
  );

endmodule

//--- source/mem_align.sv
module mem_align (
  input  hart_pkg::dmem_req_t i_req,
  input  logic [2:0]          i_funct3,
  input  hart_pkg::word_t     i_rdata,
  output hart_pkg::dmem_req_t o_dmem,
  output hart_pkg::word_t     o_load_data
);

  logic [1:0]      offset;
  logic [4:0]      lane_shift; // offset in bits
  logic [3:0]      lanes;
  hart_pkg::word_t shifted;

  assign offset     = i_req.addr[1:0];
  assign lane_shift = {offset, 3'b000};

  // funct3[1:0] gives the access size for loads and stores alike
  always_comb begin
    case (i_funct3[1:0])
      2'b00:   lanes = 4'b0001 << offset;
      2'b01:   lanes = 4'b0011 << offset; // half words sit at offset 0 or 2
      default: lanes = 4'b1111;
    endcase
  end

  assign o_dmem.addr  = {i_req.addr[31:2], 2'b00};
  assign o_dmem.ren   = i_req.ren;
  assign o_dmem.wen   = i_req.wen;
  assign o_dmem.wdata = i_req.wdata << lane_shift; // move store data into its lanes
  assign o_dmem.mask  = lanes & i_req.mask;

  // bring the addressed bytes down to bit 0 before extending
  assign shifted = i_rdata >> lane_shift;

  always_comb begin
    case (i_funct3)
      3'b000:  o_load_data = {{24{shifted[7]}}, shifted[7:0]}; // lb
      3'b001:  o_load_data = {{16{shifted[15]}}, shifted[15:0]}; // lh
      3'b100:  o_load_data = {24'b0, shifted[7:0]}; // lbu
      3'b101:  o_load_data = {16'b0, shifted[15:0]}; // lhu
      default: o_load_data = shifted;
    endcase
  end

endmodule

//--- source/execute_stage.sv
module execute_stage (
  input  hart_pkg::exec_pkt_t i_exec,
  input  hart_pkg::word_t     i_load_data,
  output hart_pkg::dmem_req_t o_dmem_req,
  output hart_pkg::wb_pkt_t   o_wb,
  output logic                o_redirect,
  output hart_pkg::word_t     o_target,
  output hart_pkg::retire_t   o_retire
);

  hart_pkg::word_t a;
  hart_pkg::word_t b;
  hart_pkg::word_t alu_res;
  hart_pkg::word_t link;
  hart_pkg::word_t wb_data;
  logic [4:0]      shamt;
  logic            br_cond;

  assign a     = i_exec.op_a;
  assign b     = i_exec.op_b;
  assign shamt = b[4:0];
  assign link  = i_exec.pc + 32'd4;

  always_comb begin
    case (i_exec.alu_op)
      hart_pkg::alu_add:  alu_res = a + b;
      hart_pkg::alu_sub:  alu_res = a - b;
      hart_pkg::alu_sll:  alu_res = a << shamt;
      hart_pkg::alu_slt:  alu_res = {31'b0, $signed(a) < $signed(b)};
      hart_pkg::alu_sltu: alu_res = {31'b0, a < b};
      hart_pkg::alu_xor:  alu_res = a ^ b;
      hart_pkg::alu_srl:  alu_res = a >> shamt;
      hart_pkg::alu_sra:  alu_res = $signed(a) >>> shamt;
      hart_pkg::alu_or:   alu_res = a | b;
      hart_pkg::alu_and:  alu_res = a & b;
      default:            alu_res = b; // pass_b for lui
    endcase
  end

  // branch condition straight from funct3
  always_comb begin
    case (i_exec.funct3)
      3'b000:  br_cond = (a == b);
      3'b001:  br_cond = (a != b);
      3'b100:  br_cond = $signed(a) < $signed(b);
      3'b101:  br_cond = $signed(a) >= $signed(b);
      3'b110:  br_cond = a < b;
      3'b111:  br_cond = a >= b;
      default: br_cond = 1'b0;
    endcase
  end

  assign o_redirect = i_exec.valid &&
                      (i_exec.is_jal || i_exec.is_jalr || (i_exec.is_branch && br_cond));
  // jalr clears bit 0 of rs1 + imm while branches and jal add the immediate to pc
  assign o_target = i_exec.is_jalr ? {alu_res[31:1], 1'b0} : i_exec.pc + i_exec.imm;

  always_comb begin
    case (i_exec.wb_sel)
      hart_pkg::wb_mem:  wb_data = i_load_data;
      hart_pkg::wb_link: wb_data = link;
      default:           wb_data = alu_res;
    endcase
  end

  // mem_align turns the byte address and unshifted data into word lanes
  assign o_dmem_req.addr  = alu_res;
  assign o_dmem_req.ren   = i_exec.valid && i_exec.is_load;
  assign o_dmem_req.wen   = i_exec.valid && i_exec.is_store;
  assign o_dmem_req.wdata = i_exec.store_data;
  assign o_dmem_req.mask  = {4{i_exec.valid && (i_exec.is_load || i_exec.is_store)}}; // idle port has no lanes

  assign o_wb.en   = i_exec.valid && i_exec.rd_we; // lands at the next rising edge
  assign o_wb.addr = i_exec.rd;
  assign o_wb.data = wb_data;

  assign o_retire.valid = i_exec.valid;
  assign o_retire.pc    = i_exec.pc;
  assign o_retire.rd    = i_exec.rd_we ? i_exec.rd : 5'd0; // stores and branches report x0
  assign o_retire.data  = wb_data;

endmodule

//--- source/reg_file.sv
module reg_file (
  input  logic                i_clk,
  input  hart_pkg::reg_addr_t i_rs1_addr,
  input  hart_pkg::reg_addr_t i_rs2_addr,
  output hart_pkg::word_t     o_rs1_data,
  output hart_pkg::word_t     o_rs2_data,
  input  hart_pkg::wb_pkt_t   i_wb
);

  hart_pkg::word_t regs [1:31]; // x0 has no storage

  // one read port, with the write of this cycle forwarded
  function automatic hart_pkg::word_t read_port(input hart_pkg::reg_addr_t addr);
    hart_pkg::word_t data;
    if (addr == 5'd0) begin
      data = '0;
    end else if (i_wb.en && i_wb.addr == addr) begin
      data = i_wb.data; // execute writes the register decode is reading
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  assign o_rs1_data = read_port(i_rs1_addr);
  assign o_rs2_data = read_port(i_rs2_addr);

  always_ff @(posedge i_clk) begin
    if (i_wb.en && i_wb.addr != 5'd0) begin
      regs[i_wb.addr] <= i_wb.data;
    end
  end

endmodule

//--- source/decode_stage.sv
module decode_stage (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  hart_pkg::fetch_pkt_t i_fetch,
  input  logic                 i_flush,
  output hart_pkg::reg_addr_t  o_rs1_addr,
  output hart_pkg::reg_addr_t  o_rs2_addr,
  input  hart_pkg::word_t      i_rs1_data,
  input  hart_pkg::word_t      i_rs2_data,
  output hart_pkg::exec_pkt_t  o_exec
);

  hart_pkg::word_t     inst;
  hart_pkg::opcode_e   opc;
  hart_pkg::alu_op_e   arith_op;
  hart_pkg::exec_pkt_t dec;
  hart_pkg::word_t     imm_i;
  hart_pkg::word_t     imm_s;
  hart_pkg::word_t     imm_b;
  hart_pkg::word_t     imm_u;
  hart_pkg::word_t     imm_j;
  logic [2:0]          funct3;
  logic                funct7_alt; // bit 30 picks sub and sra

  assign inst       = i_fetch.inst;
  assign funct3     = inst[14:12];
  assign funct7_alt = inst[30];
  assign o_rs1_addr = inst[19:15]; // register file reads straight from the IF/ID word
  assign o_rs2_addr = inst[24:20];

  // immediates of every format for the opcode to pick from below
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (inst[6:0])
      hart_pkg::opc_op, hart_pkg::opc_op_imm, hart_pkg::opc_lui, hart_pkg::opc_auipc,
      hart_pkg::opc_jal, hart_pkg::opc_jalr, hart_pkg::opc_branch, hart_pkg::opc_load,
      hart_pkg::opc_store: opc = hart_pkg::opcode_e'(inst[6:0]);
      default:             opc = hart_pkg::opc_illegal; // system, fence and garbage
    endcase
  end

  // ALU operation of the register and immediate arithmetic group
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opc == hart_pkg::opc_op && funct7_alt) ? hart_pkg::alu_sub
                                                                   : hart_pkg::alu_add;
      3'b001:  arith_op = hart_pkg::alu_sll;
      3'b010:  arith_op = hart_pkg::alu_slt;
      3'b011:  arith_op = hart_pkg::alu_sltu;
      3'b100:  arith_op = hart_pkg::alu_xor;
      3'b101:  arith_op = funct7_alt ? hart_pkg::alu_sra : hart_pkg::alu_srl; // srai too
      3'b110:  arith_op = hart_pkg::alu_or;
      default: arith_op = hart_pkg::alu_and;
    endcase
  end

  always_comb begin
    dec            = '0;
    dec.valid      = i_fetch.valid && (opc != hart_pkg::opc_illegal);
    dec.pc         = i_fetch.pc;
    dec.op_a       = i_rs1_data; // most instructions read rs1
    dec.op_b       = imm_i;
    dec.store_data = i_rs2_data;
    dec.imm        = imm_i;
    dec.alu_op     = hart_pkg::alu_add;
    dec.funct3     = funct3;
    dec.wb_sel     = hart_pkg::wb_alu;
    dec.rd         = inst[11:7];
    case (opc)
      hart_pkg::opc_op: begin
        dec.op_b   = i_rs2_data;
        dec.alu_op = arith_op;
        dec.rd_we  = 1'b1;
      end
      hart_pkg::opc_op_imm: begin
        dec.alu_op = arith_op; // shamt sits in the low bits of imm_i
        dec.rd_we  = 1'b1;
      end
      hart_pkg::opc_lui: begin
        dec.op_a   = '0;
        dec.op_b   = imm_u;
        dec.imm    = imm_u;
        dec.alu_op = hart_pkg::alu_pass_b;
        dec.rd_we  = 1'b1;
      end
      hart_pkg::opc_auipc: begin
        dec.op_a  = i_fetch.pc;
        dec.op_b  = imm_u;
        dec.imm   = imm_u;
        dec.rd_we = 1'b1;
      end
      hart_pkg::opc_jal: begin
        dec.op_a   = i_fetch.pc;
        dec.op_b   = imm_j;
        dec.imm    = imm_j;
        dec.wb_sel = hart_pkg::wb_link;
        dec.rd_we  = 1'b1;
        dec.is_jal = 1'b1;
      end
      hart_pkg::opc_jalr: begin
        dec.wb_sel  = hart_pkg::wb_link; // ALU sum rs1 + imm is the target
        dec.rd_we   = 1'b1;
        dec.is_jalr = 1'b1;
      end
      hart_pkg::opc_branch: begin
        dec.op_b      = i_rs2_data; // execute compares the two registers
        dec.imm       = imm_b;
        dec.alu_op    = hart_pkg::alu_sub;
        dec.is_branch = 1'b1;
      end
      hart_pkg::opc_load: begin
        dec.wb_sel  = hart_pkg::wb_mem;
        dec.rd_we   = 1'b1;
        dec.is_load = 1'b1;
      end
      hart_pkg::opc_store: begin
        dec.op_b     = imm_s;
        dec.imm      = imm_s;
        dec.is_store = 1'b1;
      end
      default: dec.valid = 1'b0;
    endcase
    if (dec.rd == 5'd0) dec.rd_we = 1'b0; // x0 is never written
  end

  // ID/EX register
  always_ff @(posedge i_clk) begin
    o_exec <= dec;
    if (i_rst || i_flush) begin
      o_exec.valid <= 1'b0; // reset and a redirect both leave a bubble in execute
    end
  end

endmodule

//--- source/fetch_stage.sv
module fetch_stage (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  logic                 i_redirect,
  input  hart_pkg::word_t      i_target,
  input  hart_pkg::word_t      i_imem_rdata,
  output hart_pkg::word_t      o_imem_raddr,
  output hart_pkg::fetch_pkt_t o_fetch
);

  hart_pkg::word_t pc;
  hart_pkg::word_t pc_next;

  assign o_imem_raddr = pc; // imem answers in the same cycle

  // a taken transfer from execute wins over sequential fetch
  assign pc_next = i_redirect ? i_target : pc + 32'd4;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= hart_pkg::reset_addr;
    end else begin
      pc <= pc_next;
    end
  end

  // IF/ID register
  // the word fetched while execute redirects is on the wrong path and is dropped here
  always_ff @(posedge i_clk) begin
    o_fetch.valid <= !(i_rst || i_redirect);
    o_fetch.pc    <= pc;
    o_fetch.inst  <= i_imem_rdata; // payload carries no reset
  end

endmodule

//--- source/hart_pkg.sv
package hart_pkg;

  localparam int xlen = 32; // data and address width of the hart

  typedef logic [xlen-1:0] word_t; // one data or address word
  typedef logic [4:0]      reg_addr_t; // index into the 32 integer registers

  localparam word_t reset_addr = 32'h0000_0000; // first fetch address after reset

  // major opcodes of the instructions the hart executes
  // illegal covers every other encoding and becomes a bubble in decode
  typedef enum logic [6:0] {
    opc_illegal = 7'b0000000,
    opc_op      = 7'b0110011,
    opc_op_imm  = 7'b0010011,
    opc_lui     = 7'b0110111,
    opc_auipc   = 7'b0010111,
    opc_jal     = 7'b1101111,
    opc_jalr    = 7'b1100111,
    opc_branch  = 7'b1100011,
    opc_load    = 7'b0000011,
    opc_store   = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b // lui hands its immediate straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link // pc + 4 for jal and jalr
  } wb_sel_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     op_a; // rs1, pc or zero
    word_t     op_b; // rs2 or the immediate
    word_t     store_data; // rs2 as read in decode
    word_t     imm;
    alu_op_e   alu_op;
    logic [2:0] funct3; // branch condition or memory access size
    wb_sel_e   wb_sel;
    reg_addr_t rd;
    logic      rd_we; // already off when rd is x0
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_load;
    logic      is_store;
  } exec_pkt_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_pkt_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

  typedef struct packed {
    word_t      addr;
    logic       ren;
    logic       wen;
    word_t      wdata;
    logic [3:0] mask; // one bit per byte lane of the word
  } dmem_req_t;

endpackage
